/* divIter.sv */
`timescale 1ns/1ps
`include "mdu_cfg.svh"

module divIter import mduPkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic start,
    input  logic signedOp,
    input  Word  dividend,
    input  Word  divisor,
    output Word  quotient,
    output Word  remainder
);

    localparam int Xlen    = `MDU_XLEN;
    localparam int CntBits = $clog2(`MDU_DIV_CYCLE + 1);

    // Last restoring step happens on the edge where the count reads this
    localparam logic [CntBits-1:0] RunLast = CntBits'(Xlen + 1);
    localparam logic [CntBits-1:0] Done    = CntBits'(`MDU_DIV_CYCLE);

    typedef enum logic [1:0] {idle, prep, run, fix} DivState;

    DivState            state;
    logic [CntBits-1:0] cnt;
    logic               isSigned;
    logic               negQ;
    logic               negR;
    logic               dvsZero;
    Word                dvdRaw;
    Word                dvsRaw;
    Word                dvsAbs;
    Word                quo;
    Word                rem;
    logic [Xlen:0]      shifted;
    logic [Xlen+1:0]    diff;

    // One restoring step
    always_comb begin
        shifted = {rem, quo[Xlen-1]};
        diff    = {1'b0, shifted} - {2'b00, dvsAbs};
    end

    //////////////////////////////////////////////////////////////////////
    // Control
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
            cnt   <= '0;
        end else begin
            case (state)
                idle: begin
                    if (start) begin
                        state <= prep;
                        cnt   <= CntBits'(1);
                    end
                end
                prep: begin
                    state <= run;
                    cnt   <= cnt + 1'b1;
                end
                run: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == RunLast) begin
                        state <= fix;
                    end
                end
                fix: begin
                    // Pad out to the fixed latency
                    if (cnt == Done) begin
                        state <= idle;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Datapath
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        case (state)
            idle: begin
                if (start) begin
                    dvdRaw   <= dividend;
                    dvsRaw   <= divisor;
                    isSigned <= signedOp;
                end
            end
            prep: begin
                negQ    <= isSigned & (dvdRaw[Xlen-1] ^ dvsRaw[Xlen-1]);
                negR    <= isSigned & dvdRaw[Xlen-1];
                dvsZero <= (dvsRaw == '0);
                quo     <= (isSigned && dvdRaw[Xlen-1]) ? -dvdRaw : dvdRaw;
                dvsAbs  <= (isSigned && dvsRaw[Xlen-1]) ? -dvsRaw : dvsRaw;
                rem     <= '0;
            end
            run: begin
                quo <= {quo[Xlen-2:0], ~diff[Xlen+1]};
                rem <= diff[Xlen+1] ? shifted[Xlen-1:0] : diff[Xlen-1:0];
            end
            fix: begin
                if (cnt == Done) begin
                    // Divide by zero gives all ones and the dividend back
                    if (dvsZero) begin
                        quotient  <= '1;
                        remainder <= dvdRaw;
                    end else begin
                        quotient  <= negQ ? -quo : quo;
                        remainder <= negR ? -rem : rem;
                    end
                end
            end
            default: ;
        endcase
    end

endmodule

/* list.f */
+incdir+.
mduPkg.sv
physRegFile.sv
mulPipe.sv
divIter.sv
mduCore.sv
mduTop.sv
mduTb.sv

/* mduCore.sv */
`timescale 1ns/1ps
`include "mdu_cfg.svh"

module mduCore import mduPkg::*; (
    input  logic                     clk,
    input  logic                     rst,

    input  UopBundle                 uopHi,
    input  UopBundle                 uopLo,

    output logic                     mulStart,
    output logic                     mulSigned,
    output logic                     divStart,
    output logic                     divSigned,
    input  logic [2*`MDU_XLEN-1:0]   product,
    input  Word                      quotient,
    input  Word                      remainder,

    output PrfWrite                  wb,
    output RobFinish                 robFinish,
    output logic                     mulBusy,
    output logic                     divBusy
);

    localparam int Xlen = `MDU_XLEN;
    localparam int Tl   = `MDU_TIMELINE;
    localparam int MulC = `MDU_MUL_CYCLE;
    localparam int DivC = `MDU_DIV_CYCLE;

    // Multiplies landing on a divide's write slots or the slot before
    localparam logic [Tl-1:0] MulRsvMask  = Tl'(7) << (DivC - MulC - 2);
    // Busy until the divide's lo write, inclusive
    localparam logic [Tl-1:0] DivBusyMask = (Tl'(1) << (DivC + 2)) - Tl'(1);
    localparam UopBundle      NoUop       = '0;

    typedef enum logic [2:0] {idle, mulOutHi, mulOutLo, divOutHi, divOutLo} WbState;

    WbState        state;
    WbState        nxtState;
    logic [Tl-1:0] mulTimeLine;
    logic [Tl-1:0] divTimeLine;
    logic          mulAccept;
    logic          divAccept;
    UopBundle      mulQ [MulC + 2];
    UopBundle      divQ [DivC + 2];
    Word           mulLo;
    Word           divLo;
    UopBundle      outUop;
    Word           outData;

    function automatic UopBundle stamp(input UopBundle u, input logic take);
        UopBundle r;
        r       = take ? u : NoUop;
        r.valid = take;
        return r;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Issue and timelines
    //////////////////////////////////////////////////////////////////////

    assign mulBusy   = mulTimeLine[0];
    assign divBusy   = divTimeLine[0];
    assign mulAccept = uopHi.valid && !mulBusy &&
                       (uopHi.uOP == MULTHI_U || uopHi.uOP == MULTUHI_U);
    assign divAccept = uopHi.valid && !divBusy &&
                       (uopHi.uOP == DIVHI_U || uopHi.uOP == DIVUHI_U);
    assign mulStart  = mulAccept;
    assign divStart  = divAccept;
    assign mulSigned = (uopHi.uOP == MULTHI_U);
    assign divSigned = (uopHi.uOP == DIVHI_U);

    always_ff @(posedge clk) begin
        if (rst) begin
            mulTimeLine <= '0;
            divTimeLine <= '0;
        end else if (mulAccept) begin
            mulTimeLine <= (mulTimeLine >> 1) | Tl'(1);
            divTimeLine <= divTimeLine >> 1;
        end else if (divAccept) begin
            mulTimeLine <= (mulTimeLine >> 1) | MulRsvMask;
            divTimeLine <= (divTimeLine >> 1) | DivBusyMask;
        end else begin
            mulTimeLine <= mulTimeLine >> 1;
            divTimeLine <= divTimeLine >> 1;
        end
    end

    // Micro-op delay lines, entry 0 is the one being written back
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < MulC + 2; i++) begin
                mulQ[i] <= NoUop;
            end
            for (int i = 0; i < DivC + 2; i++) begin
                divQ[i] <= NoUop;
            end
        end else begin
            for (int i = 0; i < MulC + 1; i++) begin
                mulQ[i] <= mulQ[i+1];
            end
            if (mulAccept) begin
                mulQ[MulC] <= stamp(uopHi, mulAccept);
            end
            mulQ[MulC + 1] <= stamp(uopLo, mulAccept);
            for (int i = 0; i < DivC + 1; i++) begin
                divQ[i] <= divQ[i+1];
            end
            if (divAccept) begin
                divQ[DivC] <= stamp(uopHi, divAccept);
            end
            divQ[DivC + 1] <= stamp(uopLo, divAccept);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Writeback FSM
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (state)
            mulOutHi: nxtState = mulOutLo;
            divOutHi: nxtState = divOutLo;
            default: begin
                if (mulQ[1].valid) begin
                    nxtState = mulOutHi;
                end else if (divQ[1].valid) begin
                    nxtState = divOutHi;
                end else begin
                    nxtState = idle;
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
        end else begin
            state <= nxtState;
        end
    end

    // Lo halves parked for one cycle
    always_ff @(posedge clk) begin
        if (state == mulOutHi) begin
            mulLo <= product[Xlen-1:0];
        end
        if (state == divOutHi) begin
            divLo <= quotient;
        end
    end

    always_comb begin
        outUop  = NoUop;
        outData = '0;
        case (state)
            mulOutHi: begin
                outUop  = mulQ[0];
                outData = product[2*Xlen-1:Xlen];
            end
            mulOutLo: begin
                outUop  = mulQ[0];
                outData = mulLo;
            end
            divOutHi: begin
                outUop  = divQ[0];
                outData = remainder;
            end
            divOutLo: begin
                outUop  = divQ[0];
                outData = divLo;
            end
            default: ;
        endcase
        wb.wen              = outUop.valid;
        wb.rd               = outUop.dstPAddr;
        wb.wdata            = outData;
        robFinish.setFinish = outUop.valid;
        robFinish.id        = outUop.id;
    end

endmodule

/* mduPkg.sv */
`include "mdu_cfg.svh"

package mduPkg;

    typedef logic [`MDU_XLEN-1:0]     Word;
    typedef logic [`MDU_PRF_BITS-1:0] PrfNum;
    typedef logic [`MDU_ROB_BITS-1:0] RobId;

    typedef enum logic [3:0] {
        NOP_U,
        MULTHI_U,
        MULTLO_U,
        MULTUHI_U,
        MULTULO_U,
        DIVHI_U,
        DIVLO_U,
        DIVUHI_U,
        DIVULO_U
    } UopKind;

    typedef struct packed {
        logic   valid;
        UopKind uOP;
        PrfNum  src0;
        PrfNum  src1;
        PrfNum  dstPAddr;
        RobId   id;
    } UopBundle;

    typedef struct packed {
        Word rs0Data;
        Word rs1Data;
    } PrfReadData;

    typedef struct packed {
        logic  wen;
        PrfNum rd;
        Word   wdata;
    } PrfWrite;

    typedef struct packed {
        logic setFinish;
        RobId id;
    } RobFinish;

endpackage

/* mduTb.sv */
`timescale 1ns/1ps
`include "mdu_cfg.svh"

module mduTb import mduPkg::*; ();

    typedef struct packed {
        PrfWrite     wr;
        RobFinish    fin;
        logic [31:0] cycle;
    } ExpWrite;

    logic        clk;
    logic        rst;
    UopBundle    uopHi;
    UopBundle    uopLo;
    PrfWrite     load;
    PrfWrite     wb;
    RobFinish    robFinish;
    logic        mulBusy;
    logic        divBusy;

    Word         modelRegs [`MDU_PRF_COUNT];
    ExpWrite     expQ [$];
    logic [31:0] edgeCount;
    logic [31:0] lfsrState;
    string       testName;
    PrfNum       nextDst;
    PrfNum       lastHi;
    PrfNum       lastLo;
    int          maxMulHold;
    int          maxQueued;
    int          mulAccEdge;
    int          divAccEdge;

    mduTop mduTop_i (
        .clk       (clk),
        .rst       (rst),
        .uopHi     (uopHi),
        .uopLo     (uopLo),
        .load      (load),
        .wb        (wb),
        .robFinish (robFinish),
        .mulBusy   (mulBusy),
        .divBusy   (divBusy)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        edgeCount <= edgeCount + 1;
    end

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1);
    endtask

    // Right-shifting Galois form
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'hB4BC_D35C;
        end
        return s >> 1;
    endfunction

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrNext(lfsrState);
            r = {r[30:0], lfsrState[0]};
        end
        return r;
    endfunction

    function automatic UopKind pickKind(input UopKind signedKind, input UopKind unsignedKind);
        if (randBits(1) == 32'd1) begin
            return signedKind;
        end
        return unsignedKind;
    endfunction

    function automatic PrfNum randSrc();
        return PrfNum'(randBits(4));
    endfunction

    // Expected {hi, lo}: product halves, or remainder then quotient
    function automatic logic [63:0] mduRef(input UopKind kind, input Word a, input Word b);
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic [63:0]        p;
        Word                q;
        Word                r;
        sa = {{32{a[31]}}, a};
        sb = {{32{b[31]}}, b};
        p  = '0;
        case (kind)
            MULTHI_U:  p = sa * sb;
            MULTUHI_U: p = {32'd0, a} * {32'd0, b};
            DIVHI_U, DIVUHI_U: begin
                if (b == '0) begin
                    q = '1;
                    r = a;
                end else if (kind == DIVHI_U) begin
                    q = Word'(sa / sb);
                    r = Word'(sa % sb);
                end else begin
                    q = a / b;
                    r = a % b;
                end
                p = {r, q};
            end
            default: p = '0;
        endcase
        return p;
    endfunction

    // Busy expected in the cycle after an accept, and around the divide's write slots
    function automatic logic expectBusy(input logic isMul);
        int now;
        int rsv;
        now = int'(edgeCount);
        rsv = divAccEdge + `MDU_DIV_CYCLE - `MDU_MUL_CYCLE;
        if (isMul) begin
            return (now == mulAccEdge) || (now >= rsv - 2 && now <= rsv);
        end
        return (now >= divAccEdge) && (now <= divAccEdge + `MDU_DIV_CYCLE + 1);
    endfunction

    task automatic checkWord(input string name, input Word expected, input Word actual);
        if (expected !== actual) begin
            abortRun($sformatf("Mismatch in %s: expected %h, actual %h",
                               name, expected, actual));
        end
    endtask

    task automatic checkWrite(input string name, input PrfWrite expected, input PrfWrite actual);
        if (expected !== actual) begin
            abortRun($sformatf("Mismatch in %s: expected wen=%b rd=%0d wdata=%h, actual wen=%b rd=%0d wdata=%h",
                               name, expected.wen, expected.rd, expected.wdata,
                               actual.wen, actual.rd, actual.wdata));
        end
    endtask

    task automatic checkFinish(input string name, input RobFinish expected, input RobFinish actual);
        if (expected !== actual) begin
            abortRun($sformatf("Mismatch in %s: expected finish=%b id=%0d, actual finish=%b id=%0d",
                               name, expected.setFinish, expected.id,
                               actual.setFinish, actual.id));
        end
    endtask

    task automatic checkBusy(input string name, input logic expected, input logic actual);
        if (expected !== actual) begin
            abortRun($sformatf("Mismatch in %s: expected busy=%b, actual busy=%b",
                               name, expected, actual));
        end
    endtask

    task automatic loadReg(input PrfNum idx, input Word val);
        load = '{wen: 1'b1, rd: idx, wdata: val};
        modelRegs[idx] = val;
        @(negedge clk);
        load = '0;
    endtask

    task automatic expectWrite(input PrfNum dst, input Word data, input RobId robId,
                               input logic [31:0] slot);
        ExpWrite e;
        foreach (expQ[i]) begin
            if (expQ[i].cycle == slot) begin
                abortRun($sformatf("%s: two writes expected in cycle %0d", testName, slot));
            end
        end
        e.wr    = '{wen: 1'b1, rd: dst, wdata: data};
        e.fin   = '{setFinish: 1'b1, id: robId};
        e.cycle = slot;
        expQ.push_back(e);
    endtask

    // Called just after a falling edge, returns one falling edge after acceptance
    task automatic issuePair(input UopKind kind, input PrfNum s0, input PrfNum s1);
        logic        isMul;
        logic        busy;
        int          waited;
        int          lat;
        logic [63:0] res;
        RobId        idHi;
        RobId        idLo;
        isMul  = (kind == MULTHI_U || kind == MULTUHI_U);
        idHi   = RobId'(randBits(5));
        idLo   = RobId'(randBits(5));
        lastHi = nextDst;
        lastLo = nextDst + 6'd1;
        nextDst = (nextDst == 6'd62) ? 6'd32 : nextDst + 6'd2;
        uopHi = '{valid: 1'b1, uOP: kind, src0: s0, src1: s1, dstPAddr: lastHi, id: idHi};
        uopLo = '{valid: 1'b1, uOP: UopKind'(kind + 4'd1), src0: 6'd0, src1: 6'd0,
                  dstPAddr: lastLo, id: idLo};
        waited = 0;
        busy   = isMul ? mulBusy : divBusy;
        checkBusy(testName, expectBusy(isMul), busy);
        while (busy) begin
            @(negedge clk);
            waited++;
            if (waited > 100) begin
                abortRun($sformatf("%s: pair held under busy for too long", testName));
            end
            busy = isMul ? mulBusy : divBusy;
            checkBusy(testName, expectBusy(isMul), busy);
        end
        if (isMul && waited > maxMulHold) begin
            maxMulHold = waited;
        end
        // Accepted on the coming rising edge
        if (isMul) begin
            mulAccEdge = int'(edgeCount) + 1;
        end else begin
            divAccEdge = int'(edgeCount) + 1;
        end
        res = mduRef(kind, modelRegs[s0], modelRegs[s1]);
        lat = isMul ? `MDU_MUL_CYCLE : `MDU_DIV_CYCLE;
        expectWrite(lastHi, res[63:32], idHi, edgeCount + 1 + lat);
        expectWrite(lastLo, res[31:0], idLo, edgeCount + 2 + lat);
        if (expQ.size() > maxQueued) begin
            maxQueued = expQ.size();
        end
        @(negedge clk);
        uopHi = '0;
        uopLo = '0;
    endtask

    task automatic drainWrites();
        int waited;
        waited = 0;
        while (expQ.size() != 0) begin
            @(negedge clk);
            waited++;
            if (waited > 200) begin
                abortRun($sformatf("%s: expected writes did not arrive in time", testName));
            end
        end
        // Let the last write settle in the register file
        repeat (2) @(negedge clk);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Writeback monitor
    //////////////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        int hit;
        hit = -1;
        foreach (expQ[i]) begin
            if (expQ[i].cycle == edgeCount) begin
                hit = i;
            end
        end
        if (wb.wen && hit < 0) begin
            abortRun($sformatf("%s: write to register %0d in cycle %0d was not expected",
                               testName, wb.rd, edgeCount));
        end else if (wb.wen) begin
            checkWord(testName, expQ[hit].wr.wdata, wb.wdata);
            checkWrite(testName, expQ[hit].wr, wb);
            checkFinish(testName, expQ[hit].fin, robFinish);
            modelRegs[wb.rd] = wb.wdata;
            expQ.delete(hit);
        end else if (hit >= 0) begin
            abortRun($sformatf("%s: write to register %0d missing in cycle %0d",
                               testName, expQ[hit].wr.rd, edgeCount));
        end else if (robFinish.setFinish) begin
            abortRun($sformatf("%s: finish reported in cycle %0d without a write",
                               testName, edgeCount));
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////////////////////////

    initial begin
        clk            = 1'b0;
        rst            = 1'b1;
        uopHi          = '0;
        uopLo          = '0;
        load           = '0;
        edgeCount      = '0;
        lfsrState      = 32'h5624_4787;
        testName       = "reset";
        nextDst        = 6'd32;
        lastHi         = '0;
        lastLo         = '0;
        maxMulHold     = 0;
        maxQueued      = 0;
        mulAccEdge     = -1000;
        divAccEdge     = -1000;
        for (int i = 0; i < `MDU_PRF_COUNT; i++) begin
            modelRegs[i] = '0;
        end
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        if (mulBusy || divBusy) begin
            abortRun("busy level still high after reset");
        end

        // Operands in 0..15, corner values in 8..12
        for (int i = 0; i < 8; i++) begin
            loadReg(PrfNum'(i), randBits(32));
        end
        loadReg(6'd8, 32'h0000_0000);
        loadReg(6'd9, 32'h0000_0001);
        loadReg(6'd10, 32'hFFFF_FFFF);
        loadReg(6'd11, 32'h8000_0000);
        loadReg(6'd12, 32'h7FFF_FFFF);
        for (int i = 13; i < 16; i++) begin
            loadReg(PrfNum'(i), randBits(8));
        end

        testName = "mulRandom";
        for (int i = 0; i < 12; i++) begin
            issuePair(pickKind(MULTHI_U, MULTUHI_U), randSrc(), randSrc());
        end
        issuePair(MULTHI_U, 6'd11, 6'd11);
        issuePair(MULTUHI_U, 6'd10, 6'd10);
        issuePair(MULTHI_U, 6'd10, 6'd11);
        issuePair(MULTUHI_U, 6'd11, 6'd9);
        issuePair(MULTHI_U, 6'd8, 6'd12);
        issuePair(MULTHI_U, 6'd12, 6'd10);
        drainWrites();

        testName = "divide";
        issuePair(DIVHI_U, 6'd0, 6'd8);
        issuePair(DIVUHI_U, 6'd1, 6'd8);
        issuePair(DIVHI_U, 6'd11, 6'd10);
        issuePair(DIVUHI_U, 6'd11, 6'd10);
        issuePair(DIVHI_U, 6'd10, 6'd9);
        for (int i = 0; i < 5; i++) begin
            issuePair(pickKind(DIVHI_U, DIVUHI_U), randSrc(), randSrc());
        end
        drainWrites();

        testName = "mulStream";
        maxQueued = 0;
        for (int i = 0; i < 8; i++) begin
            issuePair(pickKind(MULTHI_U, MULTUHI_U), randSrc(), randSrc());
        end
        drainWrites();
        if (maxQueued < 6) begin
            abortRun("fewer than three multiplies were in flight together");
        end

        testName = "divMulMix";
        maxMulHold = 0;
        issuePair(pickKind(DIVHI_U, DIVUHI_U), randSrc(), randSrc());
        for (int i = 0; i < 20; i++) begin
            issuePair(pickKind(MULTHI_U, MULTUHI_U), randSrc(), randSrc());
        end
        drainWrites();
        if (maxMulHold < 3) begin
            abortRun("mulBusy did not hold a multiply around the divide write slots");
        end

        // Sources are results of the previous pair
        testName = "dependency";
        issuePair(MULTUHI_U, 6'd12, 6'd13);
        drainWrites();
        issuePair(DIVHI_U, lastLo, lastHi);
        drainWrites();
        issuePair(MULTHI_U, lastHi, lastLo);
        drainWrites();
        issuePair(DIVUHI_U, lastLo, 6'd14);
        drainWrites();

        $display("test passed");
        $finish;
    end

endmodule

/* mduTop.sv */
`timescale 1ns/1ps
`include "mdu_cfg.svh"

module mduTop import mduPkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  UopBundle uopHi,
    input  UopBundle uopLo,
    input  PrfWrite  load,
    output PrfWrite  wb,
    output RobFinish robFinish,
    output logic     mulBusy,
    output logic     divBusy
);

    PrfReadData              rdata;
    logic                    mulStart;
    logic                    mulSigned;
    logic                    divStart;
    logic                    divSigned;
    logic [2*`MDU_XLEN-1:0]  product;
    Word                     quotient;
    Word                     remainder;

    physRegFile physRegFile_i (
        .clk     (clk),
        .rst     (rst),
        .rdAddr0 (uopHi.src0),
        .rdAddr1 (uopHi.src1),
        .rdata   (rdata),
        .wrA     (load),
        .wrB     (wb)
    );

    mulPipe mulPipe_i (
        .clk      (clk),
        .start    (mulStart),
        .signedOp (mulSigned),
        .a        (rdata.rs0Data),
        .b        (rdata.rs1Data),
        .product  (product)
    );

    divIter divIter_i (
        .clk       (clk),
        .rst       (rst),
        .start     (divStart),
        .signedOp  (divSigned),
        .dividend  (rdata.rs0Data),
        .divisor   (rdata.rs1Data),
        .quotient  (quotient),
        .remainder (remainder)
    );

    mduCore mduCore_i (
        .clk       (clk),
        .rst       (rst),
        .uopHi     (uopHi),
        .uopLo     (uopLo),
        .mulStart  (mulStart),
        .mulSigned (mulSigned),
        .divStart  (divStart),
        .divSigned (divSigned),
        .product   (product),
        .quotient  (quotient),
        .remainder (remainder),
        .wb        (wb),
        .robFinish (robFinish),
        .mulBusy   (mulBusy),
        .divBusy   (divBusy)
    );

endmodule

/* mdu_cfg.svh */
`ifndef MDU_CFG_SVH
`define MDU_CFG_SVH

// Datapath and register file
`define MDU_XLEN        32
`define MDU_PRF_COUNT   64
`define MDU_PRF_BITS    6
`define MDU_ROB_BITS    5

// Fixed unit latencies, in clock edges from the accepting edge
`define MDU_MUL_CYCLE   4
`define MDU_DIV_CYCLE   36

// Reservation window of the issue timelines
`define MDU_TIMELINE    40

`endif

/* mulPipe.sv */
`timescale 1ns/1ps
`include "mdu_cfg.svh"

module mulPipe import mduPkg::*; (
    input  logic                     clk,
    input  logic                     start,
    input  logic                     signedOp,
    input  Word                      a,
    input  Word                      b,
    output logic [2*`MDU_XLEN-1:0]   product
);

    localparam int Xlen   = `MDU_XLEN;
    localparam int Stages = `MDU_MUL_CYCLE + 1;

    logic signed [Xlen:0]     aExt;
    logic signed [Xlen:0]     bExt;
    logic signed [2*Xlen+1:0] full;
    logic [2*Xlen-1:0]        stage [Stages];

    // One extra bit makes the unsigned case a signed multiply too
    always_comb begin
        aExt = {signedOp & a[Xlen-1], a};
        bExt = {signedOp & b[Xlen-1], b};
        full = aExt * bExt;
    end

    // Stage 0 loads on the start edge, last stage is read the cycle after edge MUL_CYCLE
    always_ff @(posedge clk) begin
        stage[0] <= start ? full[2*Xlen-1:0] : '0;
        for (int i = 1; i < Stages; i++) begin
            stage[i] <= stage[i-1];
        end
    end

    assign product = stage[Stages-1];

endmodule

/* physRegFile.sv */
`timescale 1ns/1ps
`include "mdu_cfg.svh"

module physRegFile import mduPkg::*; (
    input  logic       clk,
    input  logic       rst,

    input  PrfNum      rdAddr0,
    input  PrfNum      rdAddr1,
    output PrfReadData rdata,

    input  PrfWrite    wrA,
    input  PrfWrite    wrB
);

    Word regs [`MDU_PRF_COUNT];

    // Second port is applied last so it wins on a shared address
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `MDU_PRF_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wrA.wen) begin
                regs[wrA.rd] <= wrA.wdata;
            end
            if (wrB.wen) begin
                regs[wrB.rd] <= wrB.wdata;
            end
        end
    end

    // Plain read, a write in this cycle shows up next cycle
    always_comb begin
        rdata.rs0Data = regs[rdAddr0];
        rdata.rs1Data = regs[rdAddr1];
    end

endmodule

/* run.sh */
#!/bin/sh
# Build and run the MDU testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing -Wno-fatal -f list.f --top-module mduTb -o simv; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/simv > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "test failed" "$LOG"; then
    echo "Simulation reported a failure, see $LOG"
    exit 1
fi
if [ "$status" -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi
if ! grep -q "test passed" "$LOG"; then
    echo "Simulation ended without a result, see $LOG"
    exit 1
fi
exit 0
